//--- hdl/roce_ctrl_pkg.sv
// roce control plane definitions
`default_nettype none

package roce_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [31:0]  ip_addr_t;
  typedef logic [47:0]  mac_addr_t;
  typedef logic [23:0]  qpn_t;
  typedef logic [23:0]  psn_t;
  typedef logic [15:0]  rkey_t;
  typedef logic [47:0]  vaddr_t;
  typedef logic [15:0]  udp_port_t;
  typedef logic [2:0]   rdma_op_t;
  typedef logic [31:0]  xfer_len_t;
  typedef logic [3:0]   board_t;
  typedef logic [143:0] qp_ctx_t;
  typedef logic [183:0] conn_rec_t;
  typedef logic [159:0] tx_meta_t;
  typedef logic [31:0]  wait_cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // record layouts, lsb of each field
  ////////////////////////////////////////////////////////////////////////////
  localparam int qp_state_lsb   = 0;
  localparam int qp_rqpn_lsb    = 3;
  localparam int qp_rpsn_lsb    = 27;
  localparam int qp_lpsn_lsb    = 51;
  localparam int qp_rkey_lsb    = 75;
  localparam int qp_vaddr_lsb   = 91;
  localparam logic [2:0] qp_ready_recv = 3'd2;

  localparam int conn_lqpn_lsb  = 0;
  localparam int conn_lqpn_w    = 16;  // only the low bits of the local qpn
  localparam int conn_rqpn_lsb  = 16;
  localparam int conn_rip_lsb   = 136;
  localparam int conn_udp_lsb   = 168;

  localparam int meta_op_lsb    = 0;
  localparam int meta_qpn_lsb   = 3;
  localparam int meta_laddr_lsb = 27;
  localparam int meta_raddr_lsb = 75;
  localparam int meta_len_lsb   = 123;

  ////////////////////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////////////////////
  localparam rdma_op_t op_read  = 3'd0;
  localparam rdma_op_t op_write = 3'd1;

  // fixed buffers of the read-write-read test
  localparam vaddr_t rwr_laddr_read1 = 48'h0;
  localparam vaddr_t rwr_laddr_write = 48'h200;
  localparam vaddr_t rwr_laddr_read2 = 48'h100;

  localparam mac_addr_t base_mac = 48'hE59D02350A00;  // lsb first, 00:0A:35:02:9D:E5
  localparam ip_addr_t reset_local_ip  = 32'hD1D4010B;
  localparam ip_addr_t reset_remote_ip = 32'hD2D4010B;

  localparam logic [31:0] idle_cycles_default = 32'd250000000;  // settle delay
  localparam logic [31:0] run_cycles_default  = 32'd500000000;

  typedef enum logic [1:0] {
    mode_none = 2'd0,
    mode_rwr  = 2'd1,
    mode_op   = 2'd2
  } kernel_mode_e;

  typedef enum logic [2:0] {
    s_idle,
    s_qp,
    s_conn,
    s_meta_op,
    s_meta_read1,
    s_meta_write,
    s_meta_read2
  } seq_state_e;

endpackage

`default_nettype wire

//--- hdl/kernel_ctrl.sv
// kernel start and done control
`timescale 1ns/1ps
`default_nettype none

module kernel_ctrl #(
  parameter logic [31:0] RUN_CYCLES = roce_ctrl_pkg::run_cycles_default
) (
  input  wire  net_clk,
  input  wire  net_aresetn,
  input  wire  ap_start,
  output logic start_pulse,
  output logic ap_idle,
  output logic ap_done
);

  logic        ap_start_r;
  logic [31:0] run_cnt;

  assign start_pulse = ap_start & ~ap_start_r;  // rising edge of the start level

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      ap_start_r <= 1'b0;
      ap_idle    <= 1'b1;
    end else begin
      ap_start_r <= ap_start;
      if (ap_done) begin
        ap_idle <= 1'b1;
      end else if (start_pulse) begin
        ap_idle <= 1'b0;
      end
    end
  end

  // run timer, advances only while start is held
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      run_cnt <= '0;
      ap_done <= 1'b0;
    end else begin
      ap_done <= 1'b0;
      if (run_cnt == RUN_CYCLES) begin
        run_cnt <= '0;
        ap_done <= 1'b1;  // single cycle
      end else if (ap_start) begin
        run_cnt <= run_cnt + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/addr_config.sv
// station address registers
`timescale 1ns/1ps
`default_nettype none

module addr_config (
  input  wire                       net_clk,
  input  wire                       net_aresetn,
  input  wire                       start_pulse,
  input  wire roce_ctrl_pkg::ip_addr_t local_ip_in,
  input  wire roce_ctrl_pkg::ip_addr_t remote_ip_in,
  input  wire [1:0]                 board_sel,
  output roce_ctrl_pkg::ip_addr_t   remote_ip,
  output roce_ctrl_pkg::ip_addr_t   ip_addr,
  output roce_ctrl_pkg::mac_addr_t  mac_addr,
  output roce_ctrl_pkg::ip_addr_t   gateway
);

  roce_ctrl_pkg::ip_addr_t local_ip_r;
  roce_ctrl_pkg::board_t   board_r;

  // host writes addresses msb first, the stack wants them lsb first
  function automatic roce_ctrl_pkg::ip_addr_t byte_swap(input roce_ctrl_pkg::ip_addr_t a);
    return {a[7:0], a[15:8], a[23:16], a[31:24]};
  endfunction

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      local_ip_r <= roce_ctrl_pkg::reset_local_ip;
      remote_ip  <= roce_ctrl_pkg::reset_remote_ip;
      board_r    <= '0;
    end else if (start_pulse) begin
      local_ip_r <= byte_swap(local_ip_in);
      remote_ip  <= byte_swap(remote_ip_in);
      board_r    <= {2'b00, board_sel};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // derived station values
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      ip_addr  <= '0;
      mac_addr <= '0;
      gateway  <= '0;
    end else begin
      ip_addr  <= local_ip_r;
      // board number lands in one nibble, carry dropped
      mac_addr <= {roce_ctrl_pkg::base_mac[47:44],
                   roce_ctrl_pkg::base_mac[43:40] + board_r,
                   roce_ctrl_pkg::base_mac[39:0]};
      gateway  <= {local_ip_r[31:28], 4'h1, local_ip_r[23:0]};
    end
  end

endmodule

`default_nettype wire

//--- hdl/qp_setup_seq.sv
// queue pair setup sequencer
`timescale 1ns/1ps
`default_nettype none

module qp_setup_seq #(
  parameter logic [31:0] IDLE_CYCLES = roce_ctrl_pkg::idle_cycles_default
) (
  input  wire                          net_clk,
  input  wire                          net_aresetn,
  input  wire                          ap_start,
  input  wire                          start_pulse,
  input  var  roce_ctrl_pkg::kernel_mode_e mode,
  input  wire [11:0]                   wait_limit,
  input  wire roce_ctrl_pkg::qpn_t     rqpn,
  input  wire roce_ctrl_pkg::qpn_t     lqpn,
  input  wire roce_ctrl_pkg::psn_t     rpsn,
  input  wire roce_ctrl_pkg::psn_t     lpsn,
  input  wire roce_ctrl_pkg::rkey_t    rkey,
  input  wire roce_ctrl_pkg::vaddr_t   vaddr,
  input  wire roce_ctrl_pkg::udp_port_t rudp,
  input  wire roce_ctrl_pkg::ip_addr_t remote_ip,
  input  wire roce_ctrl_pkg::rdma_op_t op,
  input  wire roce_ctrl_pkg::vaddr_t   laddr,
  input  wire roce_ctrl_pkg::vaddr_t   raddr,
  input  wire roce_ctrl_pkg::xfer_len_t len,
  output logic                         qp_valid,
  input  wire                          qp_ready,
  output roce_ctrl_pkg::qp_ctx_t       qp_data,
  output logic                         conn_valid,
  input  wire                          conn_ready,
  output roce_ctrl_pkg::conn_rec_t     conn_data,
  output logic                         meta_valid,
  input  wire                          meta_ready,
  output roce_ctrl_pkg::tx_meta_t      meta_data
);

  roce_ctrl_pkg::seq_state_e state;
  roce_ctrl_pkg::wait_cnt_t  wait_cnt;
  logic                      seq_done;  // blocks a rerun until the next start
  logic                      test_state;
  logic                      meta_load;
  roce_ctrl_pkg::qp_ctx_t    qp_next;
  roce_ctrl_pkg::conn_rec_t  conn_next;
  roce_ctrl_pkg::tx_meta_t   meta_next;

  function automatic roce_ctrl_pkg::tx_meta_t pack_meta(
    input roce_ctrl_pkg::rdma_op_t cmd_op,
    input roce_ctrl_pkg::vaddr_t   cmd_laddr,
    input roce_ctrl_pkg::vaddr_t   cmd_raddr
  );
    roce_ctrl_pkg::tx_meta_t m;
    m = '0;
    m[roce_ctrl_pkg::meta_op_lsb +: $bits(cmd_op)]       = cmd_op;
    m[roce_ctrl_pkg::meta_qpn_lsb +: $bits(lqpn)]        = lqpn;
    m[roce_ctrl_pkg::meta_laddr_lsb +: $bits(cmd_laddr)] = cmd_laddr;
    m[roce_ctrl_pkg::meta_raddr_lsb +: $bits(cmd_raddr)] = cmd_raddr;
    m[roce_ctrl_pkg::meta_len_lsb +: $bits(len)]         = len;
    return m;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // record packing
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    qp_next = '0;
    qp_next[roce_ctrl_pkg::qp_state_lsb +: 3]            = roce_ctrl_pkg::qp_ready_recv;
    qp_next[roce_ctrl_pkg::qp_rqpn_lsb +: $bits(rqpn)]   = rqpn;
    qp_next[roce_ctrl_pkg::qp_rpsn_lsb +: $bits(rpsn)]   = rpsn;
    qp_next[roce_ctrl_pkg::qp_lpsn_lsb +: $bits(lpsn)]   = lpsn;
    qp_next[roce_ctrl_pkg::qp_rkey_lsb +: $bits(rkey)]   = rkey;
    qp_next[roce_ctrl_pkg::qp_vaddr_lsb +: $bits(vaddr)] = vaddr;

    conn_next = '0;  // keeps the reserved middle field at zero
    conn_next[roce_ctrl_pkg::conn_lqpn_lsb +: roce_ctrl_pkg::conn_lqpn_w] =
      lqpn[roce_ctrl_pkg::conn_lqpn_w-1:0];
    conn_next[roce_ctrl_pkg::conn_rqpn_lsb +: $bits(rqpn)]     = rqpn;
    conn_next[roce_ctrl_pkg::conn_rip_lsb +: $bits(remote_ip)] = remote_ip;
    conn_next[roce_ctrl_pkg::conn_udp_lsb +: $bits(rudp)]      = rudp;
  end

  always_comb begin
    case (state)
      roce_ctrl_pkg::s_meta_read1:
        meta_next = pack_meta(roce_ctrl_pkg::op_read, roce_ctrl_pkg::rwr_laddr_read1, '0);
      roce_ctrl_pkg::s_meta_write:
        meta_next = pack_meta(roce_ctrl_pkg::op_write, roce_ctrl_pkg::rwr_laddr_write, '0);
      roce_ctrl_pkg::s_meta_read2:
        meta_next = pack_meta(roce_ctrl_pkg::op_read, roce_ctrl_pkg::rwr_laddr_read2, '0);
      default:
        meta_next = pack_meta(op, laddr, raddr);  // operator command
    endcase
  end

  assign test_state = (state == roce_ctrl_pkg::s_meta_read1) ||
                      (state == roce_ctrl_pkg::s_meta_write) ||
                      (state == roce_ctrl_pkg::s_meta_read2);
  assign meta_load  = (state == roce_ctrl_pkg::s_meta_op) ? !meta_valid
                                                          : test_state && (wait_cnt == '0);

  // payload only loads while its valid is low, so it holds during a stall
  always_ff @(posedge net_clk) begin
    if (state == roce_ctrl_pkg::s_qp && !qp_valid) begin
      qp_data <= qp_next;
    end
    if (state == roce_ctrl_pkg::s_conn && !conn_valid) begin
      conn_data <= conn_next;
    end
    if (meta_load) begin
      meta_data <= meta_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // sequencer FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge net_clk) begin
    if (!net_aresetn || start_pulse) begin
      state      <= roce_ctrl_pkg::s_idle;
      wait_cnt   <= '0;
      seq_done   <= 1'b0;
      qp_valid   <= 1'b0;
      conn_valid <= 1'b0;
      meta_valid <= 1'b0;
    end else begin
      case (state)
        roce_ctrl_pkg::s_idle: begin
          if (ap_start && !seq_done) begin
            wait_cnt <= wait_cnt + 32'd1;
            if (wait_cnt == IDLE_CYCLES) begin
              wait_cnt <= '0;
              state    <= roce_ctrl_pkg::s_qp;
            end
          end
        end
        roce_ctrl_pkg::s_qp: begin
          qp_valid <= 1'b1;
          if (qp_valid && qp_ready) begin
            qp_valid <= 1'b0;
            state    <= roce_ctrl_pkg::s_conn;
          end
        end
        roce_ctrl_pkg::s_conn: begin
          conn_valid <= 1'b1;
          if (conn_valid && conn_ready) begin
            conn_valid <= 1'b0;
            case (mode)
              roce_ctrl_pkg::mode_op:  state <= roce_ctrl_pkg::s_meta_op;
              roce_ctrl_pkg::mode_rwr: state <= roce_ctrl_pkg::s_meta_read1;
              default: begin
                seq_done <= 1'b1;  // setup only
                state    <= roce_ctrl_pkg::s_idle;
              end
            endcase
          end
        end
        roce_ctrl_pkg::s_meta_op: begin
          meta_valid <= 1'b1;
          if (meta_valid && meta_ready) begin
            meta_valid <= 1'b0;
            seq_done   <= 1'b1;
            state      <= roce_ctrl_pkg::s_idle;
          end
        end
        default: begin
          // read-write-read steps, fixed length of wait_limit+1 cycles each
          if (meta_valid && meta_ready) begin
            meta_valid <= 1'b0;
          end
          if (wait_cnt == '0) begin
            meta_valid <= 1'b1;
          end
          wait_cnt <= wait_cnt + 32'd1;
          if (wait_cnt[11:0] == wait_limit) begin
            wait_cnt <= '0;
            seq_done <= (state == roce_ctrl_pkg::s_meta_read2);
            state    <= (state == roce_ctrl_pkg::s_meta_read1) ? roce_ctrl_pkg::s_meta_write :
                        (state == roce_ctrl_pkg::s_meta_write) ? roce_ctrl_pkg::s_meta_read2 :
                                                                 roce_ctrl_pkg::s_idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/tx_meta_merge.sv
// tx command merger
`timescale 1ns/1ps
`default_nettype none

module tx_meta_merge (
  input  wire                          net_clk,
  input  wire                          net_aresetn,
  input  wire                          host_valid,
  output logic                         host_ready,
  input  wire roce_ctrl_pkg::tx_meta_t host_data,
  input  wire                          role_valid,
  output logic                         role_ready,
  input  wire roce_ctrl_pkg::tx_meta_t role_data,
  output logic                         out_valid,
  input  wire                          out_ready,
  output roce_ctrl_pkg::tx_meta_t      out_data
);

  logic can_accept;
  logic grant_host;
  logic last_host;  // host won the previous arbitration

  // output slot free now or drained this cycle
  assign can_accept = !out_valid || out_ready;

  // alternate when both sources compete
  assign grant_host = host_valid && !(role_valid && last_host);
  assign host_ready = can_accept && grant_host;
  assign role_ready = can_accept && role_valid && !grant_host;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      out_valid <= 1'b0;
      last_host <= 1'b0;
    end else if (can_accept) begin
      out_valid <= host_valid || role_valid;
      if (host_ready) begin
        last_host <= 1'b1;
      end else if (role_ready) begin
        last_host <= 1'b0;
      end
    end
  end

  always_ff @(posedge net_clk) begin
    if (host_ready) begin
      out_data <= host_data;
    end else if (role_ready) begin
      out_data <= role_data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/roce_ctrl_top.sv
// roce control plane top
`timescale 1ns/1ps
`default_nettype none

module roce_ctrl_top #(
  parameter logic [31:0] IDLE_CYCLES = roce_ctrl_pkg::idle_cycles_default,
  parameter logic [31:0] RUN_CYCLES  = roce_ctrl_pkg::run_cycles_default
) (
  input  wire                           net_clk,
  input  wire                           net_aresetn,
  input  wire                           ap_start,
  output logic                          ap_idle,
  output logic                          ap_done,
  input  wire roce_ctrl_pkg::psn_t      rpsn,
  input  wire roce_ctrl_pkg::psn_t      lpsn,
  input  wire roce_ctrl_pkg::qpn_t      rqpn,
  input  wire roce_ctrl_pkg::qpn_t      lqpn,
  input  wire roce_ctrl_pkg::ip_addr_t  rip,
  input  wire roce_ctrl_pkg::ip_addr_t  lip,
  input  wire roce_ctrl_pkg::udp_port_t rudp,
  input  wire roce_ctrl_pkg::vaddr_t    vaddr,
  input  wire roce_ctrl_pkg::rkey_t     rkey,
  input  wire roce_ctrl_pkg::rdma_op_t  op,
  input  wire roce_ctrl_pkg::vaddr_t    raddr,
  input  wire roce_ctrl_pkg::vaddr_t    laddr,
  input  wire roce_ctrl_pkg::xfer_len_t len,
  input  wire [15:0]                    debug,
  input  wire                           role_meta_valid,
  output logic                          role_meta_ready,
  input  wire roce_ctrl_pkg::tx_meta_t  role_meta_data,
  output logic                          qp_valid,
  input  wire                           qp_ready,
  output roce_ctrl_pkg::qp_ctx_t        qp_data,
  output logic                          conn_valid,
  input  wire                           conn_ready,
  output roce_ctrl_pkg::conn_rec_t      conn_data,
  output logic                          meta_valid,
  input  wire                           meta_ready,
  output roce_ctrl_pkg::tx_meta_t       meta_data,
  output roce_ctrl_pkg::ip_addr_t       ip_addr,
  output roce_ctrl_pkg::mac_addr_t      mac_addr,
  output roce_ctrl_pkg::ip_addr_t       gateway
);

  logic                       start_pulse;
  roce_ctrl_pkg::ip_addr_t    remote_ip;
  roce_ctrl_pkg::kernel_mode_e kernel_mode;
  logic                       host_meta_valid;
  logic                       host_meta_ready;
  roce_ctrl_pkg::tx_meta_t    host_meta_data;

  // debug word: [1:0] mode, [3:2] board, [15:4] test step length
  assign kernel_mode = roce_ctrl_pkg::kernel_mode_e'(debug[1:0]);

  kernel_ctrl #(.RUN_CYCLES(RUN_CYCLES)) kernel_ctrl_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn), .ap_start(ap_start),
    .start_pulse(start_pulse), .ap_idle(ap_idle), .ap_done(ap_done)
  );

  addr_config addr_config_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn), .start_pulse(start_pulse),
    .local_ip_in(lip), .remote_ip_in(rip), .board_sel(debug[3:2]),
    .remote_ip(remote_ip), .ip_addr(ip_addr), .mac_addr(mac_addr), .gateway(gateway)
  );

  qp_setup_seq #(.IDLE_CYCLES(IDLE_CYCLES)) qp_setup_seq_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn), .ap_start(ap_start),
    .start_pulse(start_pulse), .mode(kernel_mode), .wait_limit(debug[15:4]),
    .rqpn(rqpn), .lqpn(lqpn), .rpsn(rpsn), .lpsn(lpsn), .rkey(rkey), .vaddr(vaddr),
    .rudp(rudp), .remote_ip(remote_ip), .op(op), .laddr(laddr), .raddr(raddr), .len(len),
    .qp_valid(qp_valid), .qp_ready(qp_ready), .qp_data(qp_data),
    .conn_valid(conn_valid), .conn_ready(conn_ready), .conn_data(conn_data),
    .meta_valid(host_meta_valid), .meta_ready(host_meta_ready), .meta_data(host_meta_data)
  );

  // host commands share the tx command path with the application role
  tx_meta_merge tx_meta_merge_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn),
    .host_valid(host_meta_valid), .host_ready(host_meta_ready), .host_data(host_meta_data),
    .role_valid(role_meta_valid), .role_ready(role_meta_ready), .role_data(role_meta_data),
    .out_valid(meta_valid), .out_ready(meta_ready), .out_data(meta_data)
  );

endmodule

`default_nettype wire

//--- verif/roce_ctrl_props.sv
// control plane protocol checks
`timescale 1ns/1ps
`default_nettype none

module roce_ctrl_props (
  input wire                            net_clk,
  input wire                            net_aresetn,
  input wire                            ap_idle,
  input wire                            ap_done,
  input wire                            qp_valid,
  input wire                            qp_ready,
  input wire roce_ctrl_pkg::qp_ctx_t    qp_data,
  input wire                            conn_valid,
  input wire                            conn_ready,
  input wire roce_ctrl_pkg::conn_rec_t  conn_data,
  input wire                            meta_valid,
  input wire                            meta_ready,
  input wire roce_ctrl_pkg::tx_meta_t   meta_data
);

  int unsigned fail_count = 0;  // failed assertions so far

  // a record holds until it transfers
  qp_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    qp_valid && !qp_ready |=> qp_valid && $stable(qp_data))
    else begin
      $error("qp record dropped or changed before transfer");
      fail_count++;
    end
  conn_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    conn_valid && !conn_ready |=> conn_valid && $stable(conn_data))
    else begin
      $error("conn record dropped or changed before transfer");
      fail_count++;
    end
  meta_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    meta_valid && !meta_ready |=> meta_valid && $stable(meta_data))
    else begin
      $error("meta record dropped or changed before transfer");
      fail_count++;
    end

  done_single: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    ap_done |=> !ap_done)
    else begin
      $error("ap_done high for two cycles");
      fail_count++;
    end

  idle_quiet: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    ap_idle |-> !qp_valid && !conn_valid && !meta_valid)
    else begin
      $error("record valid while kernel idle");
      fail_count++;
    end

endmodule

bind roce_ctrl_top roce_ctrl_props roce_ctrl_props_inst (
  .net_clk(net_clk), .net_aresetn(net_aresetn), .ap_idle(ap_idle), .ap_done(ap_done),
  .qp_valid(qp_valid), .qp_ready(qp_ready), .qp_data(qp_data),
  .conn_valid(conn_valid), .conn_ready(conn_ready), .conn_data(conn_data),
  .meta_valid(meta_valid), .meta_ready(meta_ready), .meta_data(meta_data)
);

`default_nettype wire

//--- verif/roce_ctrl_tb.sv
// roce control plane testbench
`timescale 1ns/1ps
`default_nettype none

module roce_ctrl_tb;

  localparam int clk_period  = 40;
  localparam int test_cycles = 1200;  // rough sum of all test lengths
  localparam int role_count  = 12;

  logic net_clk, net_aresetn, ap_start, ap_idle, ap_done;
  logic [23:0] rpsn, lpsn, rqpn, lqpn;
  logic [31:0] rip, lip, len;
  logic [15:0] rudp, rkey, debug;
  logic [47:0] vaddr, raddr, laddr;
  logic [2:0] op;
  logic role_meta_valid, role_meta_ready;
  logic [159:0] role_meta_data;
  logic qp_valid, qp_ready, conn_valid, conn_ready, meta_valid, meta_ready;
  logic [143:0] qp_data;
  logic [183:0] conn_data;
  logic [159:0] meta_data;
  logic [31:0] ip_addr, gateway;
  logic [47:0] mac_addr;
  logic stall_en;
  logic [31:0] lcg_state = 32'd9;
  int rec_kind[$];            // 0 qp, 1 conn, 2 meta
  logic [183:0] rec_data[$];
  logic [159:0] role_q[$];

  roce_ctrl_top #(.IDLE_CYCLES(20), .RUN_CYCLES(400)) roce_ctrl_top_inst (
    .net_clk(net_clk), .net_aresetn(net_aresetn), .ap_start(ap_start), .ap_idle(ap_idle),
    .ap_done(ap_done), .rpsn(rpsn), .lpsn(lpsn), .rqpn(rqpn), .lqpn(lqpn), .rip(rip),
    .lip(lip), .rudp(rudp), .vaddr(vaddr), .rkey(rkey), .op(op), .raddr(raddr),
    .laddr(laddr), .len(len), .debug(debug), .role_meta_valid(role_meta_valid),
    .role_meta_ready(role_meta_ready), .role_meta_data(role_meta_data),
    .qp_valid(qp_valid), .qp_ready(qp_ready), .qp_data(qp_data),
    .conn_valid(conn_valid), .conn_ready(conn_ready), .conn_data(conn_data),
    .meta_valid(meta_valid), .meta_ready(meta_ready), .meta_data(meta_data),
    .ip_addr(ip_addr), .mac_addr(mac_addr), .gateway(gateway)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [183:0] got,
                               input logic [183:0] exp);
    assert (got === exp) else
      report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
  endtask

  initial begin
    net_clk = 1'b0;
    forever #(clk_period / 2) net_clk = ~net_clk;
  end

  initial begin
    #(test_cycles * 2 * clk_period);
    report_failure("timeout: the tests did not finish in time");
  end

  // bound protocol checks count their failures
  always @(roce_ctrl_top_inst.roce_ctrl_props_inst.fail_count) begin
    if (roce_ctrl_top_inst.roce_ctrl_props_inst.fail_count != 0) begin
      report_failure("a protocol assertion on the DUT outputs failed");
    end
  end

  // random back-pressure on all three record outputs
  always @(posedge net_clk) begin : ready_drive
    logic [31:0] r;
    logic        en;
    en = stall_en;  // value before this cycle's stimulus
    #2;
    r = en ? lcg_next() : 32'hFFFF_FFFF;
    qp_ready   = r[20];
    conn_ready = r[21];
    meta_ready = r[22];
  end

  always @(negedge net_clk) begin
    if (net_aresetn) begin
      if (qp_valid && qp_ready) begin
        rec_kind.push_back(0);
        rec_data.push_back(qp_data);
      end
      if (conn_valid && conn_ready) begin
        rec_kind.push_back(1);
        rec_data.push_back(conn_data);
      end
      if (meta_valid && meta_ready) begin
        rec_kind.push_back(2);
        rec_data.push_back(meta_data);
      end
    end
  end

  // a blocked role command wins the next free slot
  role_turn: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    meta_ready && role_meta_valid && !role_meta_ready |=> role_meta_ready || !meta_ready)
    else report_failure("merger did not alternate between host and role");

  task automatic reset_dut();
    ap_start = 1'b0;
    net_aresetn = 1'b0;
    repeat (2) @(posedge net_clk);
    #2 net_aresetn = 1'b1;
    rec_kind.delete();
    rec_data.delete();
    @(negedge net_clk);
    compare_value("qp_valid", qp_valid, 1'b0);
    compare_value("conn_valid", conn_valid, 1'b0);
    compare_value("meta_valid", meta_valid, 1'b0);
    compare_value("ap_done", ap_done, 1'b0);
    compare_value("ap_idle", ap_idle, 1'b1);
    @(negedge net_clk);
    compare_value("ip_addr", ip_addr, roce_ctrl_pkg::reset_local_ip);
    @(posedge net_clk);
    #2;
  endtask

  task automatic pick_fields();
    logic [63:0] w;
    rpsn = lcg_next();
    lpsn = lcg_next();
    rqpn = lcg_next();
    lqpn = lcg_next();
    rip  = lcg_next();
    lip  = lcg_next();
    len  = lcg_next();
    rudp = lcg_next();
    rkey = lcg_next();
    op   = lcg_next();
    w = {lcg_next(), lcg_next()};
    vaddr = w[47:0];
    w = {lcg_next(), lcg_next()};
    raddr = w[47:0];
    w = {lcg_next(), lcg_next()};
    laddr = w[47:0];
  endtask

  task automatic wait_records(input int n);
    int cycles;
    cycles = 0;
    while (rec_kind.size() < n) begin
      @(negedge net_clk);
      cycles++;
      if (cycles > 500) report_failure("timed out waiting for output records");
    end
  endtask

  // qp and conn layouts rebuilt from the field list
  task automatic check_setup();
    compare_value("record order", {rec_kind[0], rec_kind[1]}, {32'd0, 32'd1});
    compare_value("qp_data", rec_data[0], {5'b0, vaddr, rkey, lpsn, rpsn, rqpn, 3'd2});
    compare_value("conn_data", rec_data[1], {rudp, rip[7:0], rip[15:8], rip[23:16],
                                             rip[31:24], 96'b0, rqpn, lqpn[15:0]});
  endtask

  task automatic send_role();
    logic ok;
    wait_records(2);
    @(posedge net_clk);
    #2;
    foreach (role_q[i]) begin
      ok = 1'b0;
      role_meta_data  = role_q[i];
      role_meta_valid = 1'b1;
      while (!ok) begin
        @(negedge net_clk);
        ok = role_meta_ready;
        @(posedge net_clk);
        #2;
      end
    end
    role_meta_valid = 1'b0;
  endtask

  initial begin : main
    logic [31:0] swapped;
    logic [159:0] host_exp[3];
    logic [159:0] r;
    int hi, ri, cycles;
    ap_start = 1'b0;
    net_aresetn = 1'b0;
    stall_en = 1'b0;
    qp_ready = 1'b1;
    conn_ready = 1'b1;
    meta_ready = 1'b1;
    role_meta_valid = 1'b0;
    role_meta_data = '0;
    debug = '0;
    pick_fields();

    ////////////////////////////////////////////////////////////////////////////
    // operator command under back-pressure, plus the address registers
    ////////////////////////////////////////////////////////////////////////////
    reset_dut();
    pick_fields();
    debug = {12'd8, 2'd3, 2'd2};
    stall_en = 1'b1;
    ap_start = 1'b1;
    repeat (3) @(negedge net_clk);
    swapped = {lip[7:0], lip[15:8], lip[23:16], lip[31:24]};
    compare_value("ip_addr", ip_addr, swapped);
    compare_value("mac_addr", mac_addr, {roce_ctrl_pkg::base_mac[47:44],
      4'(roce_ctrl_pkg::base_mac[43:40] + 4'd3), roce_ctrl_pkg::base_mac[39:0]});
    compare_value("gateway", gateway, {swapped[31:28], 4'h1, swapped[23:0]});
    wait_records(3);
    repeat (20) @(negedge net_clk);
    compare_value("record count", rec_kind.size(), 3);
    check_setup();
    compare_value("meta kind", rec_kind[2], 2);
    compare_value("meta_data", rec_data[2], {5'b0, len, raddr, laddr, lqpn, op});
    stall_en = 1'b0;
    ap_start = 1'b0;

    // read-write-read with a role stream competing for the merger
    reset_dut();
    pick_fields();
    role_q.delete();
    for (int i = 0; i < role_count; i++) begin
      r = {lcg_next(), lcg_next(), lcg_next(), lcg_next(), lcg_next()};
      r[2:0] = 3'd5;  // marks role traffic
      role_q.push_back(r);
    end
    host_exp[0] = {5'b0, len, 48'h0, 48'h0, lqpn, 3'd0};
    host_exp[1] = {5'b0, len, 48'h0, 48'h200, lqpn, 3'd1};
    host_exp[2] = {5'b0, len, 48'h0, 48'h100, lqpn, 3'd0};
    debug = {12'd8, 2'd0, 2'd1};
    ap_start = 1'b1;
    fork
      send_role();
      wait_records(5 + role_count);
    join
    repeat (40) @(negedge net_clk);
    compare_value("record count", rec_kind.size(), 5 + role_count);
    check_setup();
    hi = 0;
    ri = 0;
    for (int i = 2; i < rec_kind.size(); i++) begin
      compare_value("meta kind", rec_kind[i], 2);
      if (rec_data[i][2:0] == 3'd5) begin
        compare_value("role meta_data", rec_data[i], role_q[ri]);
        ri++;
      end else begin
        compare_value("host meta_data", rec_data[i], host_exp[hi]);
        hi++;
      end
    end
    compare_value("host command count", hi, 3);
    ap_start = 1'b0;

    // setup only, then the run timer ends the kernel
    reset_dut();
    debug = {12'd8, 2'd1, 2'd0};
    ap_start = 1'b1;
    cycles = 0;
    while (!ap_done) begin
      @(negedge net_clk);
      cycles++;
      if (cycles > 600) report_failure("timed out waiting for ap_done");
    end
    @(negedge net_clk);
    compare_value("ap_idle", ap_idle, 1'b1);
    compare_value("record count", rec_kind.size(), 2);
    check_setup();
    ap_start = 1'b0;

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hdl/roce_ctrl_pkg.sv
hdl/kernel_ctrl.sv
hdl/addr_config.sv
hdl/qp_setup_seq.sv
hdl/tx_meta_merge.sv
hdl/roce_ctrl_top.sv
verif/roce_ctrl_props.sv
verif/roce_ctrl_tb.sv
